/* sim/ctm_input.txt */
# T valid pc jbtarget jal jr : one trace port cycle, hex fields
# S cycles : debug_out_ready low from idle for that many cycles, decimal
# R addr expected : register read and the expected value, hex
T 1 00001000 00002000 1 0
T 1 00001004 00000000 0 0
T 0 00001008 00003000 1 0
T 1 00002010 00001004 0 1
T 1 00001008 00005000 1 0
T 1 0000500c 0000100c 0 1
R 0 0005
R 1 0001
R 7 0000
S 30
T 1 00010000 00011000 1 0
T 1 00011010 00010004 0 1
T 1 00010008 00012000 1 0
T 1 00012010 0001000c 0 1
T 1 00010010 00013000 1 0
T 1 00013010 00010014 0 1
T 1 00010018 00014000 1 0
T 1 00014010 0001001c 0 1
T 1 00010020 00015000 1 0
T 1 00015010 00010024 0 1
T 1 00010028 00016000 1 0
R 2 0002
T 1 00020000 00021000 1 0

/* flist.f */
+incdir+include
logic/ctm_pkg.sv
logic/ctm_trace_adapter.sv
logic/ctm_counters.sv
logic/ctm_event_fifo.sv
logic/ctm_packetizer.sv
logic/ctm_top.sv
sim/ctm_tb.sv

/* Makefile */
# Verilator build and run of the core trace module testbench

VERILATOR ?= verilator
TOP       ?= ctm_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/ctm_tb.sv */
/*
 * Testbench for the core trace module, run from the project root.
 * Commands come from sim/ctm_input.txt, one per line.
 * A stall drops every event past FIFO depth plus one, so a stall must
 * outlast the trace lines that follow it.
 */
`include "ctm_consts.svh"

module ctm_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [15:0] ID   = 16'h0007;             // Own network address
  localparam int          KEEP = `CTM_FIFO_DEPTH + 1;  // Events surviving a stall

  typedef struct packed {
    logic [15:0]        src;
    ctm_pkg::pkt_type_e ptype;
    logic [15:0]        value;
  } resp_exp;

  logic                clk = 1'b0;
  logic                arst_n;
  ctm_pkg::trace_exec  trace_port;
  ctm_pkg::dii_flit    debug_in;
  logic                debug_in_ready;
  ctm_pkg::dii_flit    debug_out;
  logic                debug_out_ready;
  logic [31:0]         cycle;             // Timestamp model
  logic [31:0]         stall_until;       // Ready held low below this cycle
  logic [15:0]         lfsr = 16'd27072;
  int                  n_lines = 0;
  int                  stall_kept;
  string               cmd_lines[$];
  ctm_pkg::trace_event trace_q[$];        // Expected trace packets
  resp_exp             resp_q[$];         // Expected responses
  ctm_pkg::dii_flit    pkt_q[$];          // Packet being received
  logic [31:0]         last_ts;
  logic                have_ts = 1'b0;

  ctm_top dut_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .id              (ID),
    .trace_port      (trace_port),
    .debug_in        (debug_in),
    .debug_in_ready  (debug_in_ready),
    .debug_out       (debug_out),
    .debug_out_ready (debug_out_ready)
  );

  always #20 clk = ~clk;

  // Timestamp rule: 0 at reset release, one tick per cycle
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) cycle <= '0;
    else cycle <= cycle + 1;
  end

  // Taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic ctm_pkg::dii_flit make_flit(input logic [15:0] data, input logic last);
    make_flit.valid = 1'b1;
    make_flit.last  = last;
    make_flit.data  = data;
  endfunction

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_flit(input string name, input ctm_pkg::dii_flit exp,
                            input ctm_pkg::dii_flit got);
    if (got !== exp) begin
      $display("** Error: %s expected %h got %h", name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_kind(input string name, input ctm_pkg::event_kind_e exp,
                            input ctm_pkg::event_kind_e got);
    if (got !== exp) begin
      $display("** Error: %s expected %h got %h", name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] got);
    if (got !== exp) begin
      $display("** Error: %s expected %h got %h", name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("** Error: %s expected %h got %h", name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_trace_packet();
    ctm_pkg::trace_event e;
    logic [15:0]         exp_q[$];
    logic [31:0]         got_ts;
    if (trace_q.size() == 0 || pkt_q.size() != 10) begin
      $display("Unexpected trace packet of %0d flits", pkt_q.size());
      stop_run();
    end else begin
      e      = trace_q.pop_front();
      got_ts = {pkt_q[4].data, pkt_q[3].data};  // As delivered by the DUT
      if (have_ts && got_ts <= last_ts) begin
        $display("Trace timestamps did not increase between packets");
        stop_run();
      end
      last_ts = got_ts;
      have_ts = 1'b1;
      exp_q.push_back(`CTM_HOST_ADDR);
      exp_q.push_back(ID);
      exp_q.push_back(ctm_pkg::pkt_trace);
      exp_q.push_back(e.timestamp[15:0]);
      exp_q.push_back(e.timestamp[31:16]);
      exp_q.push_back(e.pc[15:0]);
      exp_q.push_back(e.pc[31:16]);
      exp_q.push_back(e.target[15:0]);
      exp_q.push_back(e.target[31:16]);
      exp_q.push_back(e.kind);
      check_kind("debug_out event kind", e.kind, ctm_pkg::event_kind_e'(pkt_q[9].data));
      foreach (exp_q[i]) begin
        check_flit($sformatf("debug_out trace flit %0d", i), make_flit(exp_q[i], i == 9),
                   pkt_q[i]);
      end
    end
  endtask

  task automatic check_resp_packet();
    resp_exp     r;
    logic [15:0] exp_q[$];
    if (resp_q.size() == 0 || pkt_q.size() != 4) begin
      $display("Unexpected response packet of %0d flits", pkt_q.size());
      stop_run();
    end else begin
      r = resp_q.pop_front();
      exp_q.push_back(r.src);    // Back to the requester
      exp_q.push_back(ID);
      exp_q.push_back(r.ptype);
      exp_q.push_back(r.value);
      check_word("debug_out register value", r.value, pkt_q[3].data);
      foreach (exp_q[i]) begin
        check_flit($sformatf("debug_out response flit %0d", i), make_flit(exp_q[i], i == 3),
                   pkt_q[i]);
      end
    end
  endtask

  // Output monitor, flit taken at the next rising edge
  initial begin
    forever begin
      @(negedge clk);
      if (arst_n && debug_out.valid && debug_out_ready) begin
        pkt_q.push_back(debug_out);
        if (debug_out.last) begin
          if (pkt_q.size() >= 3 && pkt_q[2].data == ctm_pkg::pkt_trace) check_trace_packet();
          else check_resp_packet();
          pkt_q.delete();
        end else if (pkt_q.size() > 10) begin
          $display("Packet on debug_out runs past 10 flits without last");
          stop_run();
        end
      end
    end
  end

  // Random back-pressure, forced low during a stall
  initial begin
    debug_out_ready <= 1'b0;
    forever begin
      @(posedge clk);
      if (cycle < stall_until) begin
        debug_out_ready <= 1'b0;
      end else begin
        lfsr = lfsr_step(lfsr);  // One step per bit
        debug_out_ready <= lfsr[0];
      end
    end
  end

  initial begin
    wait (n_lines != 0);
    repeat (10 + n_lines * 60) @(posedge clk);
    $display("Timeout after %0d cycles, the DUT stopped delivering packets", n_lines * 60);
    stop_run();
  end

  task automatic wait_drained();
    while (trace_q.size() != 0 || resp_q.size() != 0) @(negedge clk);
  endtask

  // Entered on a rising edge, returns on the edge of the handshake
  task automatic send_flit(input ctm_pkg::dii_flit f);
    debug_in <= f;
    @(negedge clk);
    while (!debug_in_ready) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic read_input();
    int    fd;
    string line;
    fd = $fopen("sim/ctm_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open sim/ctm_input.txt");
      stop_run();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") cmd_lines.push_back(line);
      end
      $fclose(fd);
    end
  endtask

  task automatic bad_line(input string line);
    $display("Input line not understood: %s", line);
    stop_run();
  endtask

  task automatic run_trace(input string args);
    logic [31:0]         v;
    logic [31:0]         pc;
    logic [31:0]         tgt;
    logic [31:0]         jal;
    logic [31:0]         jr;
    ctm_pkg::trace_exec  te;
    ctm_pkg::trace_event ev;
    if ($sscanf(args, "%h %h %h %h %h", v, pc, tgt, jal, jr) != 5) bad_line(args);
    te.valid    = v[0];
    te.pc       = pc;
    te.jbtarget = tgt;
    te.jal      = jal[0];
    te.jr       = jr[0];
    @(posedge clk);
    trace_port <= te;
    @(negedge clk);
    if (te.valid && (te.jal || te.jr)) begin
      ev.kind      = te.jal ? ctm_pkg::ev_call : ctm_pkg::ev_return;  // jal wins
      ev.pc        = te.pc;
      ev.target    = te.jbtarget;
      ev.timestamp = cycle;  // Sampled with the instruction
      if (cycle >= stall_until) begin
        trace_q.push_back(ev);
      end else if (stall_kept < KEEP) begin
        trace_q.push_back(ev);
        stall_kept++;
      end
    end
  endtask

  task automatic run_stall(input string args);
    int n;
    if ($sscanf(args, "%d", n) != 1) bad_line(args);
    @(posedge clk);
    trace_port <= '0;
    wait_drained();  // Stall starts from idle
    @(posedge clk);
    stall_until <= cycle + n;
    stall_kept  = 0;
  endtask

  task automatic run_read(input string args);
    logic [31:0] addr;
    logic [31:0] val;
    logic        known;
    resp_exp     r;
    if ($sscanf(args, "%h %h", addr, val) != 2) bad_line(args);
    known   = addr[15:0] == `CTM_REG_MOD_TYPE || addr[15:0] == `CTM_REG_VERSION ||
              addr[15:0] == `CTM_REG_DROPPED;
    r.src   = 16'h0040 + addr[15:0];  // Distinct requester per address
    r.ptype = known ? ctm_pkg::pkt_reg_resp : ctm_pkg::pkt_reg_error;
    r.value = known ? val[15:0] : 16'h0000;
    @(posedge clk);
    trace_port <= '0;
    wait_drained();
    resp_q.push_back(r);
    @(posedge clk);
    send_flit(make_flit(ID, 1'b0));
    send_flit(make_flit(r.src, 1'b0));
    send_flit(make_flit(ctm_pkg::pkt_reg_read, 1'b0));
    send_flit(make_flit(addr[15:0], 1'b1));
    debug_in <= '0;
    @(negedge clk);
    check_bit("debug_in_ready", 1'b0, debug_in_ready);  // Response pending
    wait_drained();
    @(negedge clk);
    check_bit("debug_in_ready", 1'b1, debug_in_ready);  // Response sent
  endtask

  initial begin
    arst_n      <= 1'b0;
    trace_port  <= '0;
    debug_in    <= '0;
    stall_until <= '0;
    stall_kept  = 0;
    read_input();
    if (cmd_lines.size() == 0) begin
      $display("Input file holds no commands");
      stop_run();
    end
    n_lines = cmd_lines.size();
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_bit("debug_in_ready", 1'b1, debug_in_ready);   // Idle after reset
    check_bit("debug_out valid", 1'b0, debug_out.valid);
    foreach (cmd_lines[i]) begin
      case (cmd_lines[i].getc(0))
        "T":     run_trace(cmd_lines[i].substr(2, cmd_lines[i].len() - 1));
        "S":     run_stall(cmd_lines[i].substr(2, cmd_lines[i].len() - 1));
        "R":     run_read(cmd_lines[i].substr(2, cmd_lines[i].len() - 1));
        default: bad_line(cmd_lines[i]);
      endcase
    end
    @(posedge clk);
    trace_port <= '0;
    wait_drained();
    repeat (40) @(negedge clk);  // Window for stray packets
    if (pkt_q.size() != 0) begin
      $display("Partial packet left on debug_out after the last command");
      stop_run();
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* logic/ctm_top.sv */
/*
 * Core trace module for the debug network.
 * Turns core calls and returns into timestamped trace packets and
 * answers register reads for type, version and dropped events.
 * Both debug links use a valid/ready flit handshake.
 */
`include "ctm_consts.svh"

module ctm_top (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [`CTM_FLIT_WIDTH-1:0] id,               // Own network address
  input  ctm_pkg::trace_exec         trace_port,
  input  ctm_pkg::dii_flit           debug_in,
  output logic                       debug_in_ready,
  output ctm_pkg::dii_flit           debug_out,
  input  logic                       debug_out_ready
);

  logic [`CTM_TS_WIDTH-1:0] timestamp;
  logic [15:0]              dropped;
  ctm_pkg::trace_event      evt;
  logic                     evt_push;
  ctm_pkg::trace_event      head;
  logic                     empty;
  logic                     evt_pop;
  logic                     evt_drop;

  ctm_trace_adapter adapter_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .trace_port (trace_port),
    .timestamp  (timestamp),
    .evt        (evt),
    .evt_push   (evt_push)
  );

  ctm_counters counters_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .evt_drop  (evt_drop),
    .timestamp (timestamp),
    .dropped   (dropped)
  );

  ctm_event_fifo fifo_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .evt      (evt),
    .evt_push (evt_push),
    .evt_pop  (evt_pop),
    .head     (head),
    .empty    (empty),
    .evt_drop (evt_drop)
  );

  ctm_packetizer packetizer_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .id              (id),
    .head            (head),
    .empty           (empty),
    .evt_pop         (evt_pop),
    .dropped         (dropped),
    .debug_in        (debug_in),
    .debug_in_ready  (debug_in_ready),
    .debug_out       (debug_out),
    .debug_out_ready (debug_out_ready)
  );

endmodule

/* logic/ctm_packetizer.sv */
/*
 * Serializes trace events and register-read responses into debug flits.
 * Requests are 4 flits: destination, source, type, register address.
 * A request that is arriving or waiting is served before the next trace
 * packet; a packet already started always runs to its last flit.
 * debug_in_ready stays low from the request's last flit until the
 * response has been sent.
 */
`include "ctm_consts.svh"

module ctm_packetizer (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [`CTM_FLIT_WIDTH-1:0] id,
  input  ctm_pkg::trace_event        head,
  input  logic                       empty,
  output logic                       evt_pop,
  input  logic [15:0]                dropped,
  input  ctm_pkg::dii_flit           debug_in,
  output logic                       debug_in_ready,
  output ctm_pkg::dii_flit           debug_out,
  input  logic                       debug_out_ready
);

  localparam int unsigned FW         = `CTM_FLIT_WIDTH;
  localparam logic [3:0]  TRACE_LAST = 4'd9;  // 10 flit trace packet
  localparam logic [3:0]  RESP_LAST  = 4'd3;  // 4 flit response

  ctm_pkg::pktz_state_e state;
  ctm_pkg::pktz_state_e state_nxt;
  logic [3:0]           flit_idx;    // Output flit within the packet
  logic [1:0]           req_idx;     // Input flit within the request
  logic                 req_done;    // Full request waiting for its answer
  logic                 req_busy;    // Request partly received
  logic                 req_read;    // Request type was a register read
  logic [FW-1:0]        req_src;
  logic [FW-1:0]        req_addr;
  ctm_pkg::trace_event  cur_evt;     // Event being sent
  ctm_pkg::pkt_type_e   resp_type;
  logic [FW-1:0]        resp_value;
  logic [FW-1:0]        reg_value;
  logic                 reg_known;
  logic                 in_hs;
  logic                 out_hs;
  logic                 out_end;

  assign debug_in_ready = !req_done;
  assign in_hs          = debug_in.valid && debug_in_ready;
  assign out_hs         = debug_out.valid && debug_out_ready;
  assign out_end        = out_hs && debug_out.last;
  assign req_busy       = (req_idx != 2'd0) || debug_in.valid;

  // Request collection, runs beside the output side
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_idx  <= '0;
      req_done <= 1'b0;
    end else begin
      if (in_hs) begin
        if (debug_in.last) begin
          req_idx  <= '0;
          req_done <= 1'b1;  // Hold off input until answered
        end else begin
          req_idx <= req_idx + 1'b1;
        end
      end
      if (state == ctm_pkg::st_resp && out_end) req_done <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_hs) begin
      case (req_idx)
        2'd1:    req_src  <= debug_in.data;  // Answer goes back here
        2'd2:    req_read <= (debug_in.data == FW'(ctm_pkg::pkt_reg_read));
        2'd3:    req_addr <= debug_in.data;
        default: ;                           // Destination is this module
      endcase
    end
  end

  // Register file, read only
  always_comb begin
    reg_known = 1'b1;
    case (req_addr)
      `CTM_REG_MOD_TYPE: reg_value = `CTM_MOD_TYPE;
      `CTM_REG_VERSION:  reg_value = `CTM_MOD_VERSION;
      `CTM_REG_DROPPED:  reg_value = dropped;
      default: begin
        reg_known = 1'b0;
        reg_value = '0;
      end
    endcase
  end

  always_comb begin
    state_nxt = state;
    evt_pop   = 1'b0;
    case (state)
      ctm_pkg::st_idle: begin
        if (req_done) begin
          state_nxt = ctm_pkg::st_resp;   // Pending answer first
        end else if (req_busy) begin
          state_nxt = ctm_pkg::st_req;
        end else if (!empty) begin
          state_nxt = ctm_pkg::st_trace;
          evt_pop   = 1'b1;               // Head moves into cur_evt
        end
      end
      ctm_pkg::st_req:   if (req_done) state_nxt = ctm_pkg::st_resp;
      ctm_pkg::st_trace: if (out_end)  state_nxt = ctm_pkg::st_idle;
      ctm_pkg::st_resp:  if (out_end)  state_nxt = ctm_pkg::st_idle;
      default:           state_nxt = ctm_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ctm_pkg::st_idle;
      flit_idx <= '0;
    end else begin
      state <= state_nxt;
      if (out_end) begin
        flit_idx <= '0;
      end else if (out_hs) begin
        flit_idx <= flit_idx + 1'b1;
      end
    end
  end

  // Packet payloads, frozen for the whole packet
  always_ff @(posedge clk) begin
    if (evt_pop) cur_evt <= head;
    if (state != ctm_pkg::st_resp && state_nxt == ctm_pkg::st_resp) begin
      resp_type  <= (req_read && reg_known) ? ctm_pkg::pkt_reg_resp : ctm_pkg::pkt_reg_error;
      resp_value <= (req_read && reg_known) ? reg_value : '0;  // Error carries 0
    end
  end

  always_comb begin
    debug_out = '0;
    case (state)
      ctm_pkg::st_trace: begin
        debug_out.valid = 1'b1;
        debug_out.last  = (flit_idx == TRACE_LAST);
        case (flit_idx)
          4'd0:    debug_out.data = `CTM_HOST_ADDR;
          4'd1:    debug_out.data = id;
          4'd2:    debug_out.data = FW'(ctm_pkg::pkt_trace);
          4'd3:    debug_out.data = cur_evt.timestamp[FW-1:0];
          4'd4:    debug_out.data = cur_evt.timestamp[2*FW-1:FW];
          4'd5:    debug_out.data = cur_evt.pc[FW-1:0];
          4'd6:    debug_out.data = cur_evt.pc[2*FW-1:FW];
          4'd7:    debug_out.data = cur_evt.target[FW-1:0];
          4'd8:    debug_out.data = cur_evt.target[2*FW-1:FW];
          default: debug_out.data = FW'(cur_evt.kind);  // Flit 9
        endcase
      end
      ctm_pkg::st_resp: begin
        debug_out.valid = 1'b1;
        debug_out.last  = (flit_idx == RESP_LAST);
        case (flit_idx)
          4'd0:    debug_out.data = req_src;
          4'd1:    debug_out.data = id;
          4'd2:    debug_out.data = FW'(resp_type);
          default: debug_out.data = resp_value;
        endcase
      end
      default: debug_out = '0;  // Idle or collecting
    endcase
  end

  // Link rule: a stalled flit holds until taken
  a_out_hold: assert property (
    @(posedge clk) disable iff (!arst_n)
    debug_out.valid && !debug_out_ready |=> $stable(debug_out)
  ) else $error("debug_out changed while stalled");

endmodule

/* logic/ctm_event_fifo.sv */
/*
 * Synchronous event FIFO, first word fall through.
 * A push while full is refused and reported on evt_drop, even when a
 * pop happens in the same cycle.
 * The head is valid whenever empty is low.
 */
`include "ctm_consts.svh"

module ctm_event_fifo (
  input  logic                clk,
  input  logic                arst_n,
  input  ctm_pkg::trace_event evt,
  input  logic                evt_push,
  input  logic                evt_pop,
  output ctm_pkg::trace_event head,
  output logic                empty,
  output logic                evt_drop
);

  localparam int unsigned DEPTH = `CTM_FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  ctm_pkg::trace_event mem [DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;  // Occupancy
  logic                full;
  logic                push_ok;
  logic                pop_ok;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // Wrap for any depth
  endfunction

  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign push_ok  = evt_push && !full;
  assign pop_ok   = evt_pop && !empty;
  assign evt_drop = evt_push && full;  // Lost event, goes to the counter
  assign head     = mem[rd_ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) wr_ptr <= next_ptr(wr_ptr);
      if (pop_ok)  rd_ptr <= next_ptr(rd_ptr);
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) mem[wr_ptr] <= evt;
  end

  // Packetizer must only pop a visible head
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!arst_n) evt_pop |-> !empty
  ) else $error("pop on empty event FIFO");

  a_count_bound: assert property (
    @(posedge clk) disable iff (!arst_n) count <= CNT_W'(DEPTH)
  ) else $error("event FIFO occupancy above depth");

endmodule

/* logic/ctm_counters.sv */
/*
 * Free running cycle timestamp and dropped event count.
 * The timestamp starts at 0 on reset release and wraps silently.
 * The dropped count sticks at 16'hFFFF until the next reset.
 */
`include "ctm_consts.svh"

module ctm_counters (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     evt_drop,
  output logic [`CTM_TS_WIDTH-1:0] timestamp,
  output logic [15:0]              dropped
);

  logic drop_sat;

  assign drop_sat = (dropped == 16'hFFFF);  // Counter at its ceiling

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      timestamp <= '0;
    end else begin
      timestamp <= timestamp + 1'b1;  // One tick per cycle
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dropped <= '0;
    end else if (evt_drop && !drop_sat) begin
      dropped <= dropped + 1'b1;  // Refused push from the FIFO
    end
  end

  // Host reads a monotonic count between resets
  a_dropped_monotonic: assert property (
    @(posedge clk) disable iff (!arst_n)
    dropped >= $past(dropped)
  ) else $error("dropped count went backwards");

endmodule

/* logic/ctm_trace_adapter.sv */
/*
 * Reduces the core trace port to call and return events.
 * jal marks a call, jr a return; other retired instructions are ignored.
 * The event leaves one cycle after the trace port sample.
 * The core must never flag jal and jr on the same instruction.
 */
`include "ctm_consts.svh"

module ctm_trace_adapter (
  input  logic                         clk,
  input  logic                         arst_n,
  input  ctm_pkg::trace_exec           trace_port,
  input  logic [`CTM_TS_WIDTH-1:0]     timestamp,
  output ctm_pkg::trace_event          evt,
  output logic                         evt_push
);

  logic is_call;
  logic is_ret;

  assign is_call = trace_port.valid && trace_port.jal;                     // Call wins
  assign is_ret  = trace_port.valid && trace_port.jr && !trace_port.jal;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      evt_push <= 1'b0;
    end else begin
      evt_push <= is_call || is_ret;  // One strobe per event
    end
  end

  // Event payload, valid only with evt_push
  always_ff @(posedge clk) begin
    if (is_call || is_ret) begin
      evt.kind      <= is_call ? ctm_pkg::ev_call : ctm_pkg::ev_return;
      evt.pc        <= trace_port.pc;
      evt.target    <= trace_port.jbtarget;  // Callee or return address
      evt.timestamp <= timestamp;            // Cycle of retirement
    end
  end

  // Core side protocol: an instruction is either a call or a return
  a_call_xor_ret: assert property (
    @(posedge clk) disable iff (!arst_n)
    trace_port.valid |-> !(trace_port.jal && trace_port.jr)
  ) else $error("trace port flags jal and jr together");

endmodule

/* logic/ctm_pkg.sv */
/*
 * Types shared by the core trace module.
 * Enum encodings of event kind and packet type are what travels on the
 * debug link, so host software must agree with them.
 */
`include "ctm_consts.svh"

package ctm_pkg;

  // One word of the debug link
  typedef struct packed {
    logic                       valid;
    logic                       last;  // Final flit of a packet
    logic [`CTM_FLIT_WIDTH-1:0] data;
  } dii_flit;

  // Core execution trace port, one retired instruction per valid cycle
  typedef struct packed {
    logic                       valid;
    logic [`CTM_ADDR_WIDTH-1:0] pc;
    logic [`CTM_ADDR_WIDTH-1:0] jbtarget;  // Jump or branch destination
    logic                       jal;       // Call
    logic                       jr;        // Return
  } trace_exec;

  // Sent as the last flit of a trace packet
  typedef enum logic [15:0] {
    ev_call   = 16'h0001,
    ev_return = 16'h0002
  } event_kind_e;

  // FIFO word
  typedef struct packed {
    event_kind_e                kind;
    logic [`CTM_ADDR_WIDTH-1:0] pc;
    logic [`CTM_ADDR_WIDTH-1:0] target;
    logic [`CTM_TS_WIDTH-1:0]   timestamp;
  } trace_event;

  // Third flit of every packet
  typedef enum logic [15:0] {
    pkt_reg_read  = 16'h0001,
    pkt_reg_resp  = 16'h0002,
    pkt_reg_error = 16'h0003,
    pkt_trace     = 16'h8000
  } pkt_type_e;

  typedef enum logic [1:0] {
    st_idle,   // Waiting for a request or an event
    st_trace,  // Sending trace packet flits
    st_req,    // Request arriving, trace held off
    st_resp    // Sending response flits
  } pktz_state_e;

endpackage

/* include/ctm_consts.svh */
/*
 * Shared constants of the core trace module.
 * The flit split of pc, target and timestamp assumes both are exactly
 * two flits wide (32 bits over 16-bit flits).
 * FIFO depth need not be a power of two.
 */
`ifndef CTM_CONSTS_SVH
`define CTM_CONSTS_SVH

`define CTM_ADDR_WIDTH   32        // Program counter width
`define CTM_TS_WIDTH     32        // Cycle timestamp width
`define CTM_FLIT_WIDTH   16        // Debug link data width
`define CTM_FIFO_DEPTH   8         // Buffered events

`define CTM_HOST_ADDR    16'h0000  // Trace packets go here
`define CTM_MOD_TYPE     16'h0005  // Core trace module type
`define CTM_MOD_VERSION  16'h0001

`define CTM_REG_MOD_TYPE 16'd0
`define CTM_REG_VERSION  16'd1
`define CTM_REG_DROPPED  16'd2

`endif
